//--- hdl/connectedCount_config.svh
`ifndef CONNECTEDCOUNT_CONFIG_SVH
`define CONNECTEDCOUNT_CONFIG_SVH

// Vertices per graph
`define CC_VERTICES 8

// Ring slots, also the fixed latency in non-frozen cycles
`define CC_RING_DEPTH 64

// Parallel counter cores
`define CC_CORES 4

// Job FIFO entries
`define CC_FIFO_DEPTH 8

// Free entries left when almostFull rises
`define CC_ALMOST_FULL_MARGIN 3

// Caller tag width
`define CC_TAG_WIDTH 8

`endif

//--- hdl/ccPkg.sv
`include "connectedCount_config.svh"

package ccPkg;

    // Upper triangle of the adjacency matrix, row by row
    // Bit 0 is edge (0,1), bit 1 is (0,2), the top bit is (6,7)
    typedef logic [`CC_VERTICES * (`CC_VERTICES - 1) / 2 - 1:0] graph_t;

    // Component count, 1 up to CC_VERTICES
    typedef logic [$clog2(`CC_VERTICES + 1) - 1:0] count_t;

    // Ring index
    typedef logic [$clog2(`CC_RING_DEPTH) - 1:0] slot_t;

    // Opaque caller tag, returned with the result
    typedef logic [`CC_TAG_WIDTH - 1:0] tag_t;

    // Work item for a counter core
    // The slot says where the count goes in the count memory
    typedef struct packed {
        graph_t graph;
        slot_t  slot;
    } job_t;

endpackage

//--- hdl/jobIf.sv
// One job from the dispatcher into one counter core
interface jobIf;
    import ccPkg::*;

    // Single-cycle strobe, only towards an idle core
    logic   valid;
    graph_t graph;
    slot_t  slot;

    // High while the core can take a job
    logic   idle;

    modport dispatch (
        output valid,
        output graph,
        output slot,
        input  idle
    );

    modport core (
        input  valid,
        input  graph,
        input  slot,
        output idle
    );

endinterface

//--- hdl/resultIf.sv
// One finished count from a core to the collector
interface resultIf;
    import ccPkg::*;

    // Held with stable count and slot until granted
    logic   valid;
    count_t count;
    slot_t  slot;

    // One cycle, the cycle the count memory is written
    logic   grant;

    modport core (
        output valid,
        output count,
        output slot,
        input  grant
    );

    modport collect (
        input  valid,
        input  count,
        input  slot,
        output grant
    );

endinterface

//--- hdl/slotRing.sv
`include "connectedCount_config.svh"

module slotRing (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  ccPkg::graph_t  graphIn,
    input  ccPkg::tag_t    tagIn,
    input  logic           freeze,
    output logic           jobValid,
    output ccPkg::job_t    job,
    output ccPkg::slot_t   readSlot,
    output logic           readEnable,
    output logic           resultValid,
    output ccPkg::tag_t    resultTag
);
    import ccPkg::*;

    slot_t                     curSlot;
    logic [`CC_RING_DEPTH-1:0] slotValid;
    tag_t                      tagMem [`CC_RING_DEPTH];

    // Slot advances on every non-frozen cycle
    // Old entry goes to the output stage, new entry takes its place
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            curSlot     <= '0;
            slotValid   <= '0;
            resultValid <= 1'b0;
        end else if (freeze) begin
            resultValid <= 1'b0;
        end else begin
            curSlot            <= curSlot + 1'b1;
            slotValid[curSlot] <= inValid;
            resultValid        <= slotValid[curSlot];
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            tagMem[curSlot] <= tagIn;
            resultTag       <= tagMem[curSlot];
        end
    end

    // Jobs leave in the acceptance cycle, tagged with their slot
    assign jobValid  = inValid && !freeze;
    assign job.graph = graphIn;
    assign job.slot  = curSlot;

    // Count memory is read in step with the output stage above
    assign readSlot   = curSlot;
    assign readEnable = !freeze;

    // Source must stay quiet while the ring is held
    noInputWhileFrozen: assert property (
        @(posedge clk) disable iff (!rstN) freeze |-> !inValid
    ) else $error("slotRing: inValid high during freeze");

endmodule

//--- hdl/jobDispatcher.sv
`include "connectedCount_config.svh"

module jobDispatcher (
    input  logic         clk,
    input  logic         rstN,
    input  logic         jobValid,
    input  ccPkg::job_t  job,
    output logic         almostFull,
    jobIf.dispatch       cores [`CC_CORES]
);
    import ccPkg::*;

    localparam int depth    = `CC_FIFO_DEPTH;
    localparam int ptrWidth = $clog2(depth);
    localparam int cntWidth = $clog2(depth + 1);
    localparam int numCores = `CC_CORES;

    job_t                fifoMem [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] fill;
    logic                full;
    logic                push;
    logic                pop;
    job_t                headJob;
    logic [numCores-1:0] idleVec;
    logic [numCores-1:0] dispatchVec;

    assign full    = (fill == cntWidth'(depth));
    assign push    = jobValid && !full;
    assign headJob = fifoMem[rdPtr];

    // Lowest-numbered idle core takes the head, if there is one
    assign dispatchVec = (fill != '0) ? (idleVec & (~idleVec + 1'b1)) : '0;
    assign pop         = |dispatchVec;

    for (genvar gi = 0; gi < numCores; gi++) begin : gCoreLink
        assign idleVec[gi]     = cores[gi].idle;
        assign cores[gi].valid = dispatchVec[gi];
        assign cores[gi].graph = headJob.graph;
        assign cores[gi].slot  = headJob.slot;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifoMem[wrPtr] <= job;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Leaves room for jobs already on their way from the source
    assign almostFull = (fill >= cntWidth'(depth - `CC_ALMOST_FULL_MARGIN));

    // Source ignored almostFull long enough to fill the queue
    noOverflow: assert property (
        @(posedge clk) disable iff (!rstN) jobValid |-> !full
    ) else $error("jobDispatcher: job written to a full FIFO");

endmodule

//--- hdl/componentCounter.sv
`include "connectedCount_config.svh"

module componentCounter (
    input logic     clk,
    input logic     rstN,
    jobIf.core      jobPort,
    resultIf.core   resultPort
);
    import ccPkg::*;

    localparam int numVert    = `CC_VERTICES;
    localparam int labelWidth = $clog2(numVert);

    typedef enum logic [1:0] {stIdle, stIter, stCount, stDone} state_t;

    state_t                state;
    graph_t                graphReg;
    slot_t                 slotReg;
    count_t                countReg;
    count_t                rootCount;
    logic                  changed;
    logic [numVert-1:0]    adj [numVert];
    logic [labelWidth-1:0] label [numVert];
    logic [labelWidth-1:0] nextLabel [numVert];

    // Expand the triangle into a symmetric matrix
    always_comb begin
        int b;
        b = 0;
        for (int i = 0; i < numVert; i++) begin
            adj[i] = '0;
        end
        for (int i = 0; i < numVert; i++) begin
            for (int j = i + 1; j < numVert; j++) begin
                adj[i][j] = graphReg[b];
                adj[j][i] = graphReg[b];
                b++;
            end
        end
    end

    // Each label drops to the smallest label among its neighbors
    always_comb begin
        changed = 1'b0;
        for (int i = 0; i < numVert; i++) begin
            nextLabel[i] = label[i];
            for (int j = 0; j < numVert; j++) begin
                if (adj[i][j] && (label[j] < nextLabel[i])) begin
                    nextLabel[i] = label[j];
                end
            end
            if (nextLabel[i] != label[i]) begin
                changed = 1'b1;
            end
        end
    end

    // One root per component once labels have settled
    always_comb begin
        rootCount = '0;
        for (int i = 0; i < numVert; i++) begin
            if (label[i] == labelWidth'(i)) begin
                rootCount = rootCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle:  if (jobPort.valid) state <= stIter;
                stIter:  if (!changed) state <= stCount;
                stCount: state <= stDone;
                stDone:  if (resultPort.grant) state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && jobPort.valid) begin
            graphReg <= jobPort.graph;
            slotReg  <= jobPort.slot;
            for (int i = 0; i < numVert; i++) begin
                label[i] <= labelWidth'(i);
            end
        end else if (state == stIter) begin
            for (int i = 0; i < numVert; i++) begin
                label[i] <= nextLabel[i];
            end
        end
        if (state == stCount) begin
            countReg <= rootCount;
        end
    end

    assign jobPort.idle     = (state == stIdle);
    assign resultPort.valid = (state == stDone);
    assign resultPort.count = countReg;
    assign resultPort.slot  = slotReg;

    // Dispatcher must only pick a core that reported idle
    noJobWhileBusy: assert property (
        @(posedge clk) disable iff (!rstN) jobPort.valid |-> (state == stIdle)
    ) else $error("componentCounter: job offered to a busy core");

endmodule

//--- hdl/resultCollector.sv
`include "connectedCount_config.svh"

module resultCollector (
    input  logic          clk,
    input  logic          rstN,
    input  ccPkg::slot_t  readSlot,
    input  logic          readEnable,
    input  ccPkg::slot_t  jobSlot,
    input  logic          jobValid,
    output ccPkg::count_t resultCount,
    resultIf.collect      results [`CC_CORES]
);
    import ccPkg::*;

    localparam int numCores = `CC_CORES;
    localparam int idxWidth = (numCores > 1) ? $clog2(numCores) : 1;

    logic [numCores-1:0]     reqVec;
    logic [numCores-1:0]     grantVec;
    count_t                  countVec [numCores];
    slot_t                   slotVec [numCores];
    logic [idxWidth-1:0]     rrPtr;
    logic [idxWidth-1:0]     winner;
    logic                    anyGrant;
    logic [`CC_RING_DEPTH-1:0] pending;
    count_t                  countMem [`CC_RING_DEPTH];

    for (genvar gi = 0; gi < numCores; gi++) begin : gCoreLink
        assign reqVec[gi]         = results[gi].valid;
        assign countVec[gi]       = results[gi].count;
        assign slotVec[gi]        = results[gi].slot;
        assign results[gi].grant  = grantVec[gi];
    end

    // Round robin, search starts just past the last winner
    always_comb begin
        int idx;
        grantVec = '0;
        winner   = '0;
        anyGrant = 1'b0;
        for (int k = 0; k < numCores; k++) begin
            idx = (int'(rrPtr) + k) % numCores;
            if (!anyGrant && reqVec[idx]) begin
                grantVec[idx] = 1'b1;
                winner        = idxWidth'(idx);
                anyGrant      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rrPtr   <= '0;
            pending <= '0;
        end else begin
            if (anyGrant) begin
                rrPtr <= (winner == idxWidth'(numCores - 1)) ? '0 : winner + 1'b1;
                pending[slotVec[winner]] <= 1'b0;
            end
            // A new job never shares a slot with a write-back in flight
            if (jobValid) begin
                pending[jobSlot] <= 1'b1;
            end
        end
    end

    // Single write port, owned by the granted core
    always_ff @(posedge clk) begin
        if (anyGrant) begin
            countMem[slotVec[winner]] <= countVec[winner];
        end
        if (readEnable) begin
            resultCount <= countMem[readSlot];
        end
    end

    // Every job must land before the ring comes back around
    deadlineMet: assert property (
        @(posedge clk) disable iff (!rstN) readEnable |-> !pending[readSlot]
    ) else $error("resultCollector: slot %0d read before its count arrived", readSlot);

endmodule

//--- hdl/connectedCountTop.sv
`include "connectedCount_config.svh"

module connectedCountTop (
    input  logic          clk,
    input  logic          rstN,
    input  logic          inValid,
    input  ccPkg::graph_t graphIn,
    input  ccPkg::tag_t   tagIn,
    input  logic          freeze,
    output logic          almostFull,
    output logic          resultValid,
    output ccPkg::count_t resultCount,
    output ccPkg::tag_t   resultTag
);
    import ccPkg::*;

    logic  jobValid;
    job_t  job;
    slot_t readSlot;
    logic  readEnable;

    jobIf    jobBus [`CC_CORES] ();
    resultIf resBus [`CC_CORES] ();

    slotRing ring0 (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .graphIn     (graphIn),
        .tagIn       (tagIn),
        .freeze      (freeze),
        .jobValid    (jobValid),
        .job         (job),
        .readSlot    (readSlot),
        .readEnable  (readEnable),
        .resultValid (resultValid),
        .resultTag   (resultTag)
    );

    jobDispatcher dispatch0 (
        .clk        (clk),
        .rstN       (rstN),
        .jobValid   (jobValid),
        .job        (job),
        .almostFull (almostFull),
        .cores      (jobBus)
    );

    // Identical cores, completion order is free
    for (genvar gi = 0; gi < `CC_CORES; gi++) begin : gCore
        componentCounter core (
            .clk        (clk),
            .rstN       (rstN),
            .jobPort    (jobBus[gi]),
            .resultPort (resBus[gi])
        );
    end

    // Job strobe also marks the slot pending in the collector
    resultCollector collect0 (
        .clk         (clk),
        .rstN        (rstN),
        .readSlot    (readSlot),
        .readEnable  (readEnable),
        .jobSlot     (job.slot),
        .jobValid    (jobValid),
        .resultCount (resultCount),
        .results     (resBus)
    );

endmodule

//--- dv/connectedCountTb.sv
`include "connectedCount_config.svh"

module connectedCountTb;
    timeunit 1ns;
    timeprecision 100ps;
    import ccPkg::*;

    localparam int maxRows   = 400;
    localparam int numRandom = 300;

    typedef struct {
        int     test;
        graph_t graph;
        tag_t   tag;
        int     gap;
        int     frz;
        count_t expCount;
    } row_t;

    typedef struct {
        int     dueCycle;
        count_t count;
        tag_t   tag;
        int     row;
    } expect_t;

    logic   clk;
    logic   rstN;
    logic   inValid;
    graph_t graphIn;
    tag_t   tagIn;
    logic   freeze;
    logic   almostFull;
    logic   resultValid;
    count_t resultCount;
    tag_t   resultTag;

    row_t    stimTable [maxRows];
    string   testName [5];
    int      rowCount;
    int      maxGap;
    int      maxFreeze;
    logic    tableReady;
    int      sentQ [$];
    expect_t expQ [$];
    int      activeNum;
    logic    lastActive;
    int      errorCount;
    int      checks;
    int      resultsSeen;
    int      bpWaits;

    connectedCountTop dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .graphIn     (graphIn),
        .tagIn       (tagIn),
        .freeze      (freeze),
        .almostFull  (almostFull),
        .resultValid (resultValid),
        .resultCount (resultCount),
        .resultTag   (resultTag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Union-find over the edge list
    // Each remaining root is one component
    function automatic count_t refCount(input graph_t g);
        int parent [`CC_VERTICES];
        int b;
        int ri;
        int rj;
        int roots;
        b = 0;
        roots = 0;
        for (int i = 0; i < `CC_VERTICES; i++) begin
            parent[i] = i;
        end
        for (int i = 0; i < `CC_VERTICES; i++) begin
            for (int j = i + 1; j < `CC_VERTICES; j++) begin
                if (g[b]) begin
                    ri = i;
                    while (parent[ri] != ri) ri = parent[ri];
                    rj = j;
                    while (parent[rj] != rj) rj = parent[rj];
                    if (ri != rj) parent[rj] = ri;
                end
                b++;
            end
        end
        for (int i = 0; i < `CC_VERTICES; i++) begin
            if (parent[i] == i) roots++;
        end
        return count_t'(roots);
    endfunction

    task automatic addRow(input int test, input graph_t g, input tag_t t,
                          input int gap, input int frz, input count_t cnt);
        stimTable[rowCount] = '{test, g, t, gap, frz, cnt};
        if (gap > maxGap) maxGap = gap;
        if (frz > maxFreeze) maxFreeze = frz;
        rowCount++;
    endtask

    task automatic buildTable();
        graph_t      pathG;
        logic [31:0] r;
        logic [31:0] m;
        graph_t      g;
        pathG = 28'hA442081;
        r = 32'd84443;
        // Hand-derived counts
        addRow(0, 28'h0000000, 8'h01, 2, 0, 4'd8);
        addRow(0, 28'hFFFFFFF, 8'h02, 2, 0, 4'd1);
        addRow(0, pathG,       8'h03, 2, 0, 4'd1);
        addRow(0, 28'hB402085, 8'h04, 2, 0, 4'd2);
        // Slow path next to fast graphs, so cores finish out of order
        addRow(1, pathG,       8'h11, 0, 0, refCount(pathG));
        addRow(1, 28'h0000000, 8'h12, 0, 0, refCount(28'h0000000));
        addRow(1, 28'h0000001, 8'h13, 0, 0, refCount(28'h0000001));
        addRow(1, pathG,       8'h14, 0, 0, refCount(pathG));
        addRow(1, 28'hFFFFFFF, 8'h15, 0, 0, refCount(28'hFFFFFFF));
        addRow(1, 28'h0000081, 8'h16, 0, 0, refCount(28'h0000081));
        // Freezes land while earlier results are still in the ring
        addRow(2, 28'hFFFFFFF, 8'h21, 0, 0, refCount(28'hFFFFFFF));
        addRow(2, pathG,       8'h22, 20, 50, refCount(pathG));
        addRow(2, 28'h0000000, 8'h23, 3, 5, refCount(28'h0000000));
        addRow(2, 28'h0000001, 8'h24, 0, 1, refCount(28'h0000001));
        addRow(2, 28'hB402085, 8'h25, 70, 0, refCount(28'hB402085));
        addRow(2, pathG,       8'h26, 1, 30, refCount(pathG));
        for (int k = 0; k < 24; k++) begin
            addRow(3, pathG, tag_t'(8'h40 + k), 0, 0, refCount(pathG));
        end
        for (int k = 0; k < numRandom; k++) begin
            r = xorshift(r);
            g = graph_t'(r);
            m = xorshift(r);
            // More masks give sparser graphs and larger counts
            for (int d = 0; d < int'(r[1:0]); d++) begin
                m = xorshift(m);
                g = g & graph_t'(m);
            end
            r = xorshift(m);
            addRow(4, g, tag_t'(r >> 24),
                   (r[3:0] < 4'd10) ? 0 : int'(r[5:4]),
                   (r[11:8] == 4'd0) ? int'(r[14:12]) : 0,
                   refCount(g));
        end
    endtask

    task automatic checkCount(input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0d ns: resultCount got %0d expected %0d", $time, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkTag(input tag_t got, input tag_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0d ns: resultTag got %0h expected %0h", $time, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkValid(input logic got, input bit due, input int row);
        checks++;
        if (due && got !== 1'b1) begin
            $display("** Error at %0d ns: resultValid got %b expected 1 (row %0d)",
                     $time, got, row);
            errorCount++;
        end else if (!due && got !== 1'b0) begin
            $display("At %0d ns resultValid was high although no result was due", $time);
            errorCount++;
        end
    endtask

    // Tracks the inputs the DUT samples at each non-frozen edge
    always @(posedge clk) begin
        expect_t e;
        int      k;
        if (rstN) begin
            if (freeze) begin
                lastActive = 1'b0;
            end else begin
                activeNum  = activeNum + 1;
                lastActive = 1'b1;
                if (inValid) begin
                    k = sentQ.pop_front();
                    e.dueCycle = activeNum + `CC_RING_DEPTH;
                    e.count    = stimTable[k].expCount;
                    e.tag      = stimTable[k].tag;
                    e.row      = k;
                    expQ.push_back(e);
                end
            end
        end
    end

    // Outputs settle between edges
    always @(negedge clk) begin
        expect_t e;
        if (rstN) begin
            if (lastActive && expQ.size() != 0 && expQ[0].dueCycle == activeNum) begin
                e = expQ.pop_front();
                checkValid(resultValid, 1'b1, e.row);
                if (resultValid === 1'b1) begin
                    checkCount(resultCount, e.count);
                    checkTag(resultTag, e.tag);
                end
                resultsSeen++;
            end else begin
                checkValid(resultValid, 1'b0, -1);
            end
        end
    end

    task automatic applyRow(input int k);
        repeat (stimTable[k].gap) begin
            @(posedge clk);
            inValid <= 1'b0;
            freeze  <= 1'b0;
        end
        repeat (stimTable[k].frz) begin
            @(posedge clk);
            inValid <= 1'b0;
            freeze  <= 1'b1;
        end
        @(posedge clk);
        // Source holds off while the job FIFO is nearly full
        while (almostFull) begin
            inValid <= 1'b0;
            freeze  <= 1'b0;
            bpWaits++;
            @(posedge clk);
        end
        inValid <= 1'b1;
        freeze  <= 1'b0;
        graphIn <= stimTable[k].graph;
        tagIn   <= stimTable[k].tag;
        sentQ.push_back(k);
    endtask

    task automatic drainAndReport(input int test, input int errStart, input int resStart);
        @(posedge clk);
        inValid <= 1'b0;
        freeze  <= 1'b0;
        while (sentQ.size() != 0 || expQ.size() != 0) @(posedge clk);
        if (test == 3 && bpWaits == 0) begin
            $display("almostFull never rose during the burst");
            errorCount++;
        end
        $display("Test %0d %s: %0d results, %0d errors", test, testName[test],
                 resultsSeen - resStart, errorCount - errStart);
    endtask

    initial begin
        int curTest;
        int errStart;
        int resStart;
        int tests;
        rstN        = 1'b0;
        inValid     = 1'b0;
        graphIn     = '0;
        tagIn       = '0;
        freeze      = 1'b0;
        tableReady  = 1'b0;
        rowCount    = 0;
        maxGap      = 0;
        maxFreeze   = 0;
        activeNum   = 0;
        lastActive  = 1'b0;
        errorCount  = 0;
        checks      = 0;
        resultsSeen = 0;
        bpWaits     = 0;
        tests       = 0;
        testName[0] = "known counts";
        testName[1] = "fixed latency and tag";
        testName[2] = "idle and freeze cycles";
        testName[3] = "back-pressure";
        testName[4] = "random graphs";
        buildTable();
        tableReady = 1'b1;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        curTest  = stimTable[0].test;
        errStart = 0;
        resStart = 0;
        for (int k = 0; k < rowCount; k++) begin
            if (stimTable[k].test != curTest) begin
                drainAndReport(curTest, errStart, resStart);
                tests++;
                curTest  = stimTable[k].test;
                errStart = errorCount;
                resStart = resultsSeen;
                bpWaits  = 0;
            end
            applyRow(k);
        end
        drainAndReport(curTest, errStart, resStart);
        tests++;
        $display("Summary: %0d tests, %0d results, %0d checks, %0d errors",
                 tests, resultsSeen, checks, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Budget per row covers a full ring trip plus its longest idle and freeze
    initial begin
        int limit;
        wait (tableReady == 1'b1);
        limit = rowCount * (`CC_RING_DEPTH + maxGap + maxFreeze) + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the results never all came back", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- connectedCount.f
+incdir+hdl
hdl/ccPkg.sv
hdl/jobIf.sv
hdl/resultIf.sv
hdl/slotRing.sv
hdl/jobDispatcher.sv
hdl/componentCounter.sv
hdl/resultCollector.sv
hdl/connectedCountTop.sv
dv/connectedCountTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module connectedCountTb -f connectedCount.f
	out=$$(./obj_dir/VconnectedCountTb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
